/* gfp_fetch_params.svh */
// Sizing constants for the GFP8 block fetcher
// One block is 16 packed exponent lines followed by 512 mantissa lines

`ifndef GFP_FETCH_PARAMS_SVH
`define GFP_FETCH_PARAMS_SVH

// ============================================================
// Line and element widths
// ============================================================
`define GFP_LINE_W        256
`define GFP_EXP_W         8
`define GFP_EXP_PER_LINE  32

// ============================================================
// Block layout
// ============================================================
`define GFP_EXP_LINES     16
`define GFP_MAN_LINES     512
`define GFP_EXP_COUNT     512
`define GFP_BURST_BEATS   16

// Index widths into the buffers
`define GFP_MAN_IDX_W     9
`define GFP_EXP_IDX_W     9
`define GFP_PKD_IDX_W     4

// ============================================================
// DDR addressing
// ============================================================
`define GFP_LINE_ADDR_W   26
`define GFP_AXI_ADDR_W    42
`define GFP_BYTE_SHIFT    5
// Page field in the top address bits, used by the NoC for routing
`define GFP_PAGE_ID       9'd2

`endif

/* gfp_fetch_pkg.sv */
// Shared types for the GFP8 block fetcher
// Line view, buffer write record and engine read requests

`include "gfp_fetch_params.svh"

package gfp_fetch_pkg;

    // Left or right operand buffer
    typedef enum logic {
        SIDE_LEFT  = 1'b0,
        SIDE_RIGHT = 1'b1
    } side_e;

    // One DDR line
    // Mantissa lines are kept whole, packed exponent lines are read bytewise
    typedef union packed {
        logic [`GFP_LINE_W-1:0]                       raw;
        // Byte 0 sits in the lowest bits
        logic [`GFP_EXP_PER_LINE-1:0][`GFP_EXP_W-1:0] exp;
    } gfp_line_u;

    // Line write from the fetch controller into the line buffer
    typedef struct packed {
        logic                      en;
        // Set for block lines 0..15
        logic                      is_exp;
        side_e                     side;
        // Line index within the packed or mantissa region
        logic [`GFP_MAN_IDX_W-1:0] idx;
        gfp_line_u                 data;
    } line_wr_t;

    // Engine mantissa read request
    typedef struct packed {
        logic                      en;
        logic [`GFP_MAN_IDX_W-1:0] idx;
    } man_rd_req_t;

    // Engine exponent read request, read every cycle
    typedef struct packed {
        logic [`GFP_EXP_IDX_W-1:0] idx;
    } exp_rd_req_t;

endpackage

/* fetch_control.sv */
`timescale 1ns/1ps
// GFP8 fetch controller
// Issues 33 AXI read bursts per block and turns each beat into a line write

`include "gfp_fetch_params.svh"

module fetch_control (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Command
    input  logic                        i_fetch_en,
    input  logic [`GFP_LINE_ADDR_W-1:0] i_fetch_addr,
    input  gfp_fetch_pkg::side_e        i_fetch_target,
    // AXI read address channel
    output logic                        o_ar_valid,
    output logic [`GFP_AXI_ADDR_W-1:0]  o_ar_addr,
    input  logic                        i_ar_ready,
    // AXI read data channel
    input  logic                        i_r_valid,
    input  logic [`GFP_LINE_W-1:0]      i_r_data,
    input  logic                        i_r_last,
    output logic                        o_r_ready,
    // Line buffer and unpacker
    output gfp_fetch_pkg::line_wr_t     o_line_wr,
    output logic                        o_unpack_start,
    output gfp_fetch_pkg::side_e        o_unpack_side,
    input  logic                        i_unpack_busy,
    output logic                        o_fetch_done
);
    import gfp_fetch_pkg::*;

    localparam int unsigned BLOCK_LINES = `GFP_EXP_LINES + `GFP_MAN_LINES;
    localparam int unsigned CNT_W       = $clog2(BLOCK_LINES);
    localparam int unsigned BEAT_W      = $clog2(`GFP_BURST_BEATS);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INIT,
        ST_ADDR,
        ST_EXP_DATA,
        ST_MAN_DATA,
        ST_WAIT_UNPACK,
        ST_DONE
    } state_e;

    state_e                      state_q;
    state_e                      state_d;
    logic                        fetch_en_q;
    logic                        fetch_edge;
    logic [`GFP_LINE_ADDR_W-1:0] base_q;
    side_e                       side_q;
    // Block line of the next beat (0..527)
    logic [CNT_W-1:0]            line_cnt_q;
    logic                        beat;
    logic                        last_line;
    logic [`GFP_MAN_IDX_W-1:0]   man_idx;
    logic [`GFP_LINE_ADDR_W-1:0] burst_line;
    // Registered line write
    logic                        wr_en_q;
    logic                        wr_is_exp_q;
    logic [`GFP_MAN_IDX_W-1:0]   wr_idx_q;
    gfp_line_u                   wr_data_q;

    assign fetch_edge = i_fetch_en && !fetch_en_q;
    assign beat       = i_r_valid && o_r_ready;
    assign last_line  = (line_cnt_q == CNT_W'(BLOCK_LINES - 1));
    // Mantissa lines start at block line 16
    assign man_idx    = `GFP_MAN_IDX_W'(line_cnt_q - CNT_W'(`GFP_EXP_LINES));

    // ============================================================
    // State machine
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Edges seen outside idle are dropped
                if (fetch_edge) begin
                    state_d = ST_INIT;
                end
            end
            // One settle cycle so the first AR comes two cycles after the edge
            ST_INIT: state_d = ST_ADDR;
            ST_ADDR: begin
                if (i_ar_ready) begin
                    state_d = (line_cnt_q < CNT_W'(`GFP_EXP_LINES)) ? ST_EXP_DATA : ST_MAN_DATA;
                end
            end
            ST_EXP_DATA: begin
                if (beat && i_r_last) begin
                    state_d = ST_ADDR;
                end
            end
            ST_MAN_DATA: begin
                if (beat && i_r_last) begin
                    if (!last_line) begin
                        state_d = ST_ADDR;
                    end else begin
                        // Skip the wait when unpacking is already over
                        state_d = i_unpack_busy ? ST_WAIT_UNPACK : ST_DONE;
                    end
                end
            end
            ST_WAIT_UNPACK: begin
                if (!i_unpack_busy) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q    <= ST_IDLE;
            fetch_en_q <= 1'b0;
            side_q     <= SIDE_LEFT;
            line_cnt_q <= '0;
            wr_en_q    <= 1'b0;
        end else begin
            state_q    <= state_d;
            fetch_en_q <= i_fetch_en;
            wr_en_q    <= beat;
            if (state_q == ST_IDLE && fetch_edge) begin
                side_q     <= i_fetch_target;
                line_cnt_q <= '0;
            end else if (beat) begin
                line_cnt_q <= line_cnt_q + CNT_W'(1);
            end
        end
    end

    // ============================================================
    // Command base and beat capture
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (state_q == ST_IDLE && fetch_edge) begin
            base_q <= i_fetch_addr;
        end
        if (beat) begin
            wr_is_exp_q <= (state_q == ST_EXP_DATA);
            wr_idx_q    <= (state_q == ST_EXP_DATA) ? `GFP_MAN_IDX_W'(line_cnt_q) : man_idx;
            wr_data_q   <= i_r_data;
        end
    end

    // Line counter sits on a burst boundary while in ST_ADDR
    assign burst_line = base_q + `GFP_LINE_ADDR_W'(line_cnt_q);
    assign o_ar_valid = (state_q == ST_ADDR);
    assign o_ar_addr  = {`GFP_PAGE_ID, 2'b00, burst_line, {`GFP_BYTE_SHIFT{1'b0}}};
    assign o_r_ready  = (state_q == ST_EXP_DATA) || (state_q == ST_MAN_DATA);

    always_comb begin
        o_line_wr.en     = wr_en_q;
        o_line_wr.is_exp = wr_is_exp_q;
        o_line_wr.side   = side_q;
        o_line_wr.idx    = wr_idx_q;
        o_line_wr.data   = wr_data_q;
    end

    // Unpack starts as packed line 15 goes into the buffer
    assign o_unpack_start = wr_en_q && wr_is_exp_q &&
                            (wr_idx_q == `GFP_MAN_IDX_W'(`GFP_EXP_LINES - 1));
    assign o_unpack_side  = side_q;
    assign o_fetch_done   = (state_q == ST_DONE);

    // ============================================================
    // Assertions
    // ============================================================
    // Every burst starts on a 16-line step from the base
    a_ar_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_ar_valid |-> (line_cnt_q[BEAT_W-1:0] == '0));

    a_ar_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar_addr));

    // DDR must end each burst on its sixteenth beat
    a_rlast_beat: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        beat && i_r_last |-> (line_cnt_q[BEAT_W-1:0] == BEAT_W'(`GFP_BURST_BEATS - 1)));

endmodule

/* line_buffer.sv */
`timescale 1ns/1ps
// Line storage for one fetched block
// Shared packed exponent lines plus left and right mantissa arrays

`include "gfp_fetch_params.svh"

module line_buffer (
    input  logic                              i_clk,
    // Line writes from the fetch controller
    input  gfp_fetch_pkg::line_wr_t           i_line_wr,
    // Packed exponent read for the unpacker
    input  logic [`GFP_PKD_IDX_W-1:0]         i_pkd_rd_idx,
    output gfp_fetch_pkg::gfp_line_u          o_pkd_rd_data,
    // Engine mantissa ports
    input  gfp_fetch_pkg::man_rd_req_t        i_man_rd_left,
    input  gfp_fetch_pkg::man_rd_req_t        i_man_rd_right,
    output logic [`GFP_LINE_W-1:0]            o_man_data_left,
    output logic [`GFP_LINE_W-1:0]            o_man_data_right
);
    import gfp_fetch_pkg::*;

    // ============================================================
    // Storage
    // ============================================================
    // Packed exponents, one set shared by both sides
    gfp_line_u              pkd_mem [`GFP_EXP_LINES];
    // Mantissas, first index is the side
    logic [`GFP_LINE_W-1:0] man_mem [2][`GFP_MAN_LINES];

    // Writes steered by phase flag and side
    always_ff @(posedge i_clk) begin
        if (i_line_wr.en) begin
            if (i_line_wr.is_exp) begin
                pkd_mem[i_line_wr.idx[`GFP_PKD_IDX_W-1:0]] <= i_line_wr.data;
            end else begin
                man_mem[i_line_wr.side][i_line_wr.idx] <= i_line_wr.data.raw;
            end
        end
    end

    // ============================================================
    // Read ports
    // ============================================================
    // Unpacker sees the packed line in the same cycle
    assign o_pkd_rd_data = pkd_mem[i_pkd_rd_idx];

    // Engine reads return one cycle after the request
    always_ff @(posedge i_clk) begin
        if (i_man_rd_left.en) begin
            o_man_data_left <= man_mem[SIDE_LEFT][i_man_rd_left.idx];
        end
        if (i_man_rd_right.en) begin
            o_man_data_right <= man_mem[SIDE_RIGHT][i_man_rd_right.idx];
        end
    end

    // Packed writes from the controller stay inside the 16-line region
    a_pkd_idx_range: assert property (@(posedge i_clk)
        i_line_wr.en && i_line_wr.is_exp |-> (i_line_wr.idx < `GFP_MAN_IDX_W'(`GFP_EXP_LINES)));

endmodule

/* exp_unpacker.sv */
`timescale 1ns/1ps
// Exponent unpacker
// Expands 512 packed exponent bytes into the aligned memory of one side

`include "gfp_fetch_params.svh"

module exp_unpacker (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Start from the fetch controller
    input  logic                        i_unpack_start,
    input  gfp_fetch_pkg::side_e        i_unpack_side,
    output logic                        o_unpack_busy,
    // Packed line read from the line buffer
    output logic [`GFP_PKD_IDX_W-1:0]   o_pkd_rd_idx,
    input  gfp_fetch_pkg::gfp_line_u    i_pkd_rd_data,
    // Engine exponent ports
    input  gfp_fetch_pkg::exp_rd_req_t  i_exp_rd_left,
    input  gfp_fetch_pkg::exp_rd_req_t  i_exp_rd_right,
    output logic [`GFP_EXP_W-1:0]       o_exp_data_left,
    output logic [`GFP_EXP_W-1:0]       o_exp_data_right
);
    import gfp_fetch_pkg::*;

    // Step 0 is start-up, steps 1..512 each write one exponent
    localparam int unsigned STEP_W = $clog2(`GFP_EXP_COUNT) + 1;
    localparam int unsigned BYTE_W = $clog2(`GFP_EXP_PER_LINE);

    logic [STEP_W-1:0]    step_q;
    logic                 busy_q;
    side_e                side_q;
    // Exponent written in the current step
    logic [STEP_W-1:0]    wr_pos;
    logic                 wr_en;
    logic [`GFP_EXP_W-1:0] exp_mem [2][`GFP_EXP_COUNT];

    assign wr_pos = step_q - STEP_W'(1);
    assign wr_en  = busy_q && (step_q != '0);

    // Line is pos / 32 and byte is pos mod 32
    assign o_pkd_rd_idx  = wr_pos[BYTE_W +: `GFP_PKD_IDX_W];
    assign o_unpack_busy = busy_q;

    // ============================================================
    // Step counter
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy_q <= 1'b0;
            step_q <= '0;
            side_q <= SIDE_LEFT;
        end else if (i_unpack_start) begin
            busy_q <= 1'b1;
            step_q <= '0;
            side_q <= i_unpack_side;
        end else if (busy_q) begin
            // Last write happens on step 512
            if (step_q == STEP_W'(`GFP_EXP_COUNT)) begin
                busy_q <= 1'b0;
            end else begin
                step_q <= step_q + STEP_W'(1);
            end
        end
    end

    // ============================================================
    // Aligned exponent memories
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            exp_mem[side_q][wr_pos[`GFP_EXP_IDX_W-1:0]] <= i_pkd_rd_data.exp[wr_pos[BYTE_W-1:0]];
        end
        // Engine reads, one cycle latency
        o_exp_data_left  <= exp_mem[SIDE_LEFT][i_exp_rd_left.idx];
        o_exp_data_right <= exp_mem[SIDE_RIGHT][i_exp_rd_right.idx];
    end

    // Unpacking only ever begins on a controller start pulse
    a_busy_needs_start: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $rose(busy_q) |-> $past(i_unpack_start));

endmodule

/* gfp_fetch_top.sv */
`timescale 1ns/1ps
// GFP8 block fetcher top
// Control, line buffer and exponent unpacker behind one AXI read port

`include "gfp_fetch_params.svh"

module gfp_fetch_top (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Fetch command
    input  logic                        i_fetch_en,
    input  logic [`GFP_LINE_ADDR_W-1:0] i_fetch_addr,
    input  gfp_fetch_pkg::side_e        i_fetch_target,
    output logic                        o_fetch_done,
    // AXI read address
    output logic                        o_ar_valid,
    output logic [`GFP_AXI_ADDR_W-1:0]  o_ar_addr,
    input  logic                        i_ar_ready,
    // AXI read data
    input  logic                        i_r_valid,
    input  logic [`GFP_LINE_W-1:0]      i_r_data,
    input  logic                        i_r_last,
    output logic                        o_r_ready,
    // Engine mantissa reads
    input  gfp_fetch_pkg::man_rd_req_t  i_man_rd_left,
    input  gfp_fetch_pkg::man_rd_req_t  i_man_rd_right,
    output logic [`GFP_LINE_W-1:0]      o_man_data_left,
    output logic [`GFP_LINE_W-1:0]      o_man_data_right,
    // Engine exponent reads
    input  gfp_fetch_pkg::exp_rd_req_t  i_exp_rd_left,
    input  gfp_fetch_pkg::exp_rd_req_t  i_exp_rd_right,
    output logic [`GFP_EXP_W-1:0]       o_exp_data_left,
    output logic [`GFP_EXP_W-1:0]       o_exp_data_right
);
    import gfp_fetch_pkg::*;

    line_wr_t                   line_wr;
    logic                       unpack_start;
    side_e                      unpack_side;
    logic                       unpack_busy;
    logic [`GFP_PKD_IDX_W-1:0]  pkd_rd_idx;
    gfp_line_u                  pkd_rd_data;

    fetch_control u_fetch_control (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_fetch_en     (i_fetch_en),
        .i_fetch_addr   (i_fetch_addr),
        .i_fetch_target (i_fetch_target),
        .o_ar_valid     (o_ar_valid),
        .o_ar_addr      (o_ar_addr),
        .i_ar_ready     (i_ar_ready),
        .i_r_valid      (i_r_valid),
        .i_r_data       (i_r_data),
        .i_r_last       (i_r_last),
        .o_r_ready      (o_r_ready),
        .o_line_wr      (line_wr),
        .o_unpack_start (unpack_start),
        .o_unpack_side  (unpack_side),
        .i_unpack_busy  (unpack_busy),
        .o_fetch_done   (o_fetch_done)
    );

    line_buffer u_line_buffer (
        .i_clk            (i_clk),
        .i_line_wr        (line_wr),
        .i_pkd_rd_idx     (pkd_rd_idx),
        .o_pkd_rd_data    (pkd_rd_data),
        .i_man_rd_left    (i_man_rd_left),
        .i_man_rd_right   (i_man_rd_right),
        .o_man_data_left  (o_man_data_left),
        .o_man_data_right (o_man_data_right)
    );

    exp_unpacker u_exp_unpacker (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .i_unpack_start   (unpack_start),
        .i_unpack_side    (unpack_side),
        .o_unpack_busy    (unpack_busy),
        .o_pkd_rd_idx     (pkd_rd_idx),
        .i_pkd_rd_data    (pkd_rd_data),
        .i_exp_rd_left    (i_exp_rd_left),
        .i_exp_rd_right   (i_exp_rd_right),
        .o_exp_data_left  (o_exp_data_left),
        .o_exp_data_right (o_exp_data_right)
    );

endmodule

/* tb_ddr_model.sv */
`timescale 1ns/1ps
// Behavioral DDR read responder for the GFP8 fetcher testbench
// Serves one 16-beat AXI read burst at a time with random stalls

`include "gfp_fetch_params.svh"

module tb_ddr_model (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Stall level 0..3 where higher stalls more often
    input  logic [1:0]                  i_stall,
    // AXI read address
    input  logic                        i_ar_valid,
    input  logic [`GFP_AXI_ADDR_W-1:0]  i_ar_addr,
    output logic                        o_ar_ready,
    // AXI read data
    output logic                        o_r_valid,
    output logic [`GFP_LINE_W-1:0]      o_r_data,
    output logic                        o_r_last,
    input  logic                        i_r_ready,
    // Line address of the current beat and its content from the data rule
    output logic [`GFP_LINE_ADDR_W-1:0] o_line_addr,
    input  logic [`GFP_LINE_W-1:0]      i_line_data
);
    integer     seed;
    logic       busy;
    logic [3:0] beat;

    // True when this cycle is not stalled
    function automatic logic go_now();
        int r;
        r = $random(seed);
        return (r & 3) >= int'(i_stall);
    endfunction

    initial begin
        seed        = 32'h910e_7f4a;
        busy        = 1'b0;
        beat        = '0;
        o_line_addr = '0;
        o_ar_ready  = 1'b0;
        o_r_valid   = 1'b0;
        o_r_last    = 1'b0;
        o_r_data    = '0;
    end

    // ============================================================
    // Handshakes seen on the rising edge
    // ============================================================
    always @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy <= 1'b0;
            beat <= '0;
        end else if (!busy && i_ar_valid && o_ar_ready) begin
            busy        <= 1'b1;
            beat        <= '0;
            o_line_addr <= i_ar_addr[`GFP_BYTE_SHIFT +: `GFP_LINE_ADDR_W];
        end else if (busy && o_r_valid && i_r_ready) begin
            beat        <= beat + 4'd1;
            o_line_addr <= o_line_addr + 1'b1;
            if (o_r_last) begin
                busy <= 1'b0;
            end
        end
    end

    // Outputs change on the falling edge only
    always @(negedge i_clk) begin
        o_ar_ready <= !busy && go_now();
        // A presented beat stays until taken and valid drops after the last beat
        if (!busy || !(o_r_valid && !i_r_ready)) begin
            o_r_valid <= busy && go_now();
        end
        o_r_last <= busy && (beat == 4'd15);
        o_r_data <= i_line_data;
    end

endmodule

/* tb_gfp_fetch.sv */
`timescale 1ns/1ps
// Testbench for the GFP8 block fetcher
// Runs left and right fetches against the DDR model and checks buffers

`include "gfp_fetch_params.svh"

module tb_gfp_fetch;
    import gfp_fetch_pkg::*;

    logic                        clk;
    logic                        reset_n;
    logic                        fetch_en;
    logic [`GFP_LINE_ADDR_W-1:0] fetch_addr;
    side_e                       fetch_target;
    logic                        fetch_done;
    logic                        ar_valid;
    logic [`GFP_AXI_ADDR_W-1:0]  ar_addr;
    logic                        ar_ready;
    logic                        r_valid;
    logic [`GFP_LINE_W-1:0]      r_data;
    logic                        r_last;
    logic                        r_ready;
    man_rd_req_t                 man_rd_l;
    man_rd_req_t                 man_rd_r;
    logic [`GFP_LINE_W-1:0]      man_data_l;
    logic [`GFP_LINE_W-1:0]      man_data_r;
    exp_rd_req_t                 exp_rd_l;
    exp_rd_req_t                 exp_rd_r;
    logic [`GFP_EXP_W-1:0]       exp_data_l;
    logic [`GFP_EXP_W-1:0]       exp_data_r;
    logic [1:0]                  stall;
    logic [`GFP_LINE_ADDR_W-1:0] ddr_line_addr;
    logic [`GFP_LINE_W-1:0]      ddr_line_data;

    // Check state driven on falling edges
    int                          errors;
    int                          tests_pass;
    int                          tests_fail;
    int                          ar_cnt;
    int                          done_cnt;
    logic [`GFP_LINE_ADDR_W-1:0] ar_base;
    logic                        idle_chk;
    logic                        quiet_chk;
    logic                        chk_l;
    logic                        chk_r;
    logic [`GFP_LINE_W-1:0]      want_man_l;
    logic [`GFP_LINE_W-1:0]      want_man_r;
    logic [`GFP_EXP_W-1:0]       want_exp_l;
    logic [`GFP_EXP_W-1:0]       want_exp_r;
    // Read results land one cycle after the request
    logic                        pend_l;
    logic                        pend_r;
    logic [`GFP_LINE_W-1:0]      pend_man_l;
    logic [`GFP_LINE_W-1:0]      pend_man_r;
    logic [`GFP_EXP_W-1:0]       pend_exp_l;
    logic [`GFP_EXP_W-1:0]       pend_exp_r;

    // ============================================================
    // Data rule of the DDR contents
    // ============================================================
    function automatic logic [`GFP_LINE_W-1:0] line_data(input logic [`GFP_LINE_ADDR_W-1:0] a);
        logic [`GFP_LINE_W-1:0] res;
        for (int b = 0; b < 32; b++) begin
            res[b*8 +: 8] = 8'(a * 7 + b * 37) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'(a >> 24);
        end
        return res;
    endfunction

    // Exponent k is byte k mod 32 of block line k / 32
    function automatic logic [7:0] exp_byte(input logic [`GFP_LINE_ADDR_W-1:0] base, input int k);
        logic [`GFP_LINE_W-1:0] ln;
        ln = line_data(base + `GFP_LINE_ADDR_W'(k / 32));
        return ln[(k % 32) * 8 +: 8];
    endfunction

    assign ddr_line_data = line_data(ddr_line_addr);

    gfp_fetch_top i_gfp_fetch_top (
        .i_clk            (clk),
        .i_reset_n        (reset_n),
        .i_fetch_en       (fetch_en),
        .i_fetch_addr     (fetch_addr),
        .i_fetch_target   (fetch_target),
        .o_fetch_done     (fetch_done),
        .o_ar_valid       (ar_valid),
        .o_ar_addr        (ar_addr),
        .i_ar_ready       (ar_ready),
        .i_r_valid        (r_valid),
        .i_r_data         (r_data),
        .i_r_last         (r_last),
        .o_r_ready        (r_ready),
        .i_man_rd_left    (man_rd_l),
        .i_man_rd_right   (man_rd_r),
        .o_man_data_left  (man_data_l),
        .o_man_data_right (man_data_r),
        .i_exp_rd_left    (exp_rd_l),
        .i_exp_rd_right   (exp_rd_r),
        .o_exp_data_left  (exp_data_l),
        .o_exp_data_right (exp_data_r)
    );

    tb_ddr_model u_ddr (
        .i_clk       (clk),
        .i_reset_n   (reset_n),
        .i_stall     (stall),
        .i_ar_valid  (ar_valid),
        .i_ar_addr   (ar_addr),
        .o_ar_ready  (ar_ready),
        .o_r_valid   (r_valid),
        .o_r_data    (r_data),
        .o_r_last    (r_last),
        .i_r_ready   (r_ready),
        .o_line_addr (ddr_line_addr),
        .i_line_data (ddr_line_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Burst counter, done counter and read pipelines
    always @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            ar_cnt <= ar_cnt + 1;
        end
        if (fetch_done) begin
            done_cnt <= done_cnt + 1;
        end
        pend_l     <= chk_l;
        pend_r     <= chk_r;
        pend_man_l <= want_man_l;
        pend_man_r <= want_man_r;
        pend_exp_l <= want_exp_l;
        pend_exp_r <= want_exp_r;
    end

    // ============================================================
    // Checking assertions
    // ============================================================
    a_idle_outs: assert property (@(posedge clk)
        idle_chk |-> !ar_valid && !r_ready && !fetch_done)
        else begin
            errors++;
            $display("%0t: AXI valid, ready or done high before any command", $time);
        end

    a_ar_addr: assert property (@(posedge clk) disable iff (!reset_n) ar_valid && ar_ready |->
        ar_addr == {`GFP_PAGE_ID, 2'b00, ar_base + `GFP_LINE_ADDR_W'(16 * ar_cnt), 5'b0})
        else begin
            errors++;
            $display("MISMATCH %0t ar_addr got %h expected %h", $time, ar_addr,
                     {`GFP_PAGE_ID, 2'b00, ar_base + `GFP_LINE_ADDR_W'(16 * ar_cnt), 5'b0});
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        fetch_done |=> !fetch_done)
        else begin
            errors++;
            $display("%0t: fetch done held longer than one cycle", $time);
        end

    a_quiet: assert property (@(posedge clk) quiet_chk |-> !ar_valid)
        else begin
            errors++;
            $display("%0t: AR issued after done without a new enable edge", $time);
        end

    a_man_l: assert property (@(posedge clk) pend_l |-> man_data_l == pend_man_l)
        else begin
            errors++;
            $display("MISMATCH %0t man_data_left got %h expected %h", $time,
                     man_data_l, pend_man_l);
        end

    a_man_r: assert property (@(posedge clk) pend_r |-> man_data_r == pend_man_r)
        else begin
            errors++;
            $display("MISMATCH %0t man_data_right got %h expected %h", $time,
                     man_data_r, pend_man_r);
        end

    a_exp_l: assert property (@(posedge clk) pend_l |-> exp_data_l == pend_exp_l)
        else begin
            errors++;
            $display("MISMATCH %0t exp_data_left got %h expected %h", $time,
                     exp_data_l, pend_exp_l);
        end

    a_exp_r: assert property (@(posedge clk) pend_r |-> exp_data_r == pend_exp_r)
        else begin
            errors++;
            $display("MISMATCH %0t exp_data_right got %h expected %h", $time,
                     exp_data_r, pend_exp_r);
        end

    // ============================================================
    // Tasks
    // ============================================================
    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_pass++;
            $display("test %s: pass", name);
        end else begin
            tests_fail++;
            $display("test %s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    // Raise the enable and wait for the done pulse
    task automatic run_fetch(input logic [`GFP_LINE_ADDR_W-1:0] base, input side_e side,
                             input logic hold_en);
        int n;
        @(negedge clk);
        ar_base      = base;
        ar_cnt       = 0;
        done_cnt     = 0;
        fetch_addr   = base;
        fetch_target = side;
        fetch_en     = 1'b1;
        n = 0;
        while (done_cnt == 0 && n < 40000) begin
            @(negedge clk);
            n++;
        end
        if (done_cnt == 0) begin
            $display("timeout waiting for fetch done at %0t", $time);
            $display("Simulation FAILED");
            $finish;
        end
        if (!hold_en) begin
            fetch_en = 1'b0;
        end
        repeat (4) @(negedge clk);
        assert (ar_cnt == 33) else begin
            errors++;
            $display("MISMATCH %0t ar_count got %0d expected 33", $time, ar_cnt);
        end
        assert (done_cnt == 1) else begin
            errors++;
            $display("MISMATCH %0t done_count got %0d expected 1", $time, done_cnt);
        end
    endtask

    // Read all mantissa lines and exponents of one side
    task automatic read_side(input side_e side, input logic [`GFP_LINE_ADDR_W-1:0] base);
        for (int i = 0; i < `GFP_MAN_LINES; i++) begin
            @(negedge clk);
            if (side == SIDE_LEFT) begin
                man_rd_l   = '{en: 1'b1, idx: `GFP_MAN_IDX_W'(i)};
                exp_rd_l   = '{idx: `GFP_EXP_IDX_W'(i)};
                want_man_l = line_data(base + `GFP_LINE_ADDR_W'(16 + i));
                want_exp_l = exp_byte(base, i);
                chk_l      = 1'b1;
            end else begin
                man_rd_r   = '{en: 1'b1, idx: `GFP_MAN_IDX_W'(i)};
                exp_rd_r   = '{idx: `GFP_EXP_IDX_W'(i)};
                want_man_r = line_data(base + `GFP_LINE_ADDR_W'(16 + i));
                want_exp_r = exp_byte(base, i);
                chk_r      = 1'b1;
            end
        end
        @(negedge clk);
        chk_l    = 1'b0;
        chk_r    = 1'b0;
        man_rd_l = '0;
        man_rd_r = '0;
        repeat (3) @(negedge clk);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int eb;
        reset_n      = 1'b0;
        fetch_en     = 1'b0;
        fetch_addr   = '0;
        fetch_target = SIDE_LEFT;
        man_rd_l     = '0;
        man_rd_r     = '0;
        exp_rd_l     = '0;
        exp_rd_r     = '0;
        stall        = 2'd0;
        errors       = 0;
        tests_pass   = 0;
        tests_fail   = 0;
        ar_cnt       = 0;
        done_cnt     = 0;
        ar_base      = '0;
        idle_chk     = 1'b0;
        quiet_chk    = 1'b0;
        chk_l        = 1'b0;
        chk_r        = 1'b0;
        want_man_l   = '0;
        want_man_r   = '0;
        want_exp_l   = '0;
        want_exp_r   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Outputs idle after reset
        eb = errors;
        @(negedge clk);
        idle_chk = 1'b1;
        repeat (10) @(negedge clk);
        idle_chk = 1'b0;
        report_test("reset_idle", eb);

        eb = errors;
        stall = 2'd1;
        run_fetch(26'h012_3400, SIDE_LEFT, 1'b0);
        report_test("left_fetch", eb);

        // Mantissa and exponent ports are read together
        eb = errors;
        read_side(SIDE_LEFT, 26'h012_3400);
        report_test("left_mantissa_and_exponent", eb);

        eb = errors;
        stall = 2'd2;
        run_fetch(26'h3a0_0210, SIDE_RIGHT, 1'b0);
        read_side(SIDE_RIGHT, 26'h3a0_0210);
        read_side(SIDE_LEFT, 26'h012_3400);
        report_test("right_fetch_keeps_left", eb);

        // Enable stays high well past done
        eb = errors;
        stall = 2'd3;
        run_fetch(26'h155_0000, SIDE_LEFT, 1'b1);
        quiet_chk = 1'b1;
        repeat (64) @(negedge clk);
        quiet_chk = 1'b0;
        fetch_en  = 1'b0;
        repeat (2) @(negedge clk);
        report_test("held_enable_no_refetch", eb);

        $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
        if (tests_fail == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* gfp_fetch.f */
+incdir+.
gfp_fetch_pkg.sv
fetch_control.sv
line_buffer.sv
exp_unpacker.sv
gfp_fetch_top.sv
tb_ddr_model.sv
tb_gfp_fetch.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_gfp_fetch -f gfp_fetch.f
	out=$$(./obj_dir/Vtb_gfp_fetch); echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
